//--- dv/lcd_panel_model.sv
`include "lcd_config.svh"

module lcd_panel_model (
	input  logic       clk,
	input  logic       arst_n,
	input  logic       e,
	input  logic       rs,
	input  logic       rw,
	input  logic [7:0] data,
	output logic [9:0] cap_word,	// {rs, rw, data} of the last latched word
	output int         cap_count,
	output logic       timing_err
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam int CYC_US      = `LCD_CLK_MHZ;
	localparam int POWERUP_CYC = `LCD_POWERUP_US * CYC_US;
	localparam int WORD_CYC    = `LCD_WORD_US * CYC_US;
	localparam int CLEAR_CYC   = `LCD_CLEAR_US * CYC_US;
	localparam int E_MIN_CYC   = (`LCD_E_END_US - `LCD_E_START_US) * CYC_US;
	localparam int INIT_E_CYC  = 10 * CYC_US;	// init pulses are 10 us wide

	int   cyc;	// cycles since reset release
	int   rise_cyc;
	int   prev_rise;
	int   words;
	logic e_prev;
	logic after_clear;

	task automatic flag_error(input string msg);
		$display("Fail %0t: %s", $time, msg);
		timing_err = 1'b1;
	endtask

	initial begin
		cap_word   = '0;
		cap_count  = 0;
		timing_err = 1'b0;
	end

	// panel latches the bus on the falling edge of e
	always @(negedge e) begin
		if (arst_n === 1'b1) begin
			cap_word  = {rs, rw, data};
			cap_count = cap_count + 1;
		end
	end

	// edge timing, sampled mid-cycle where the DUT outputs are settled
	always @(negedge clk) begin
		if (arst_n !== 1'b1) begin
			cyc         = 0;
			rise_cyc    = 0;
			prev_rise   = -1;
			words       = 0;
			e_prev      = 1'b0;
			after_clear = 1'b0;
		end else begin
			cyc = cyc + 1;
			if (e && !e_prev) begin
				assert (cyc >= POWERUP_CYC) else flag_error("e pulse during power-up wait");
				if (prev_rise >= 0) begin
					assert (cyc - prev_rise >= WORD_CYC) else flag_error("e rising edges too close");
					assert (!after_clear || cyc - prev_rise >= CLEAR_CYC)
						else flag_error("word sent before clear finished");
				end
				prev_rise = cyc;
				rise_cyc  = cyc;
			end
			if (!e && e_prev) begin
				assert (cyc - rise_cyc >= ((words < 4) ? INIT_E_CYC : E_MIN_CYC))
					else flag_error("e high too short");
				after_clear = (words >= 4) && !rs && (data == 8'h01);	// init clear is exempt
				words       = words + 1;
			end
			e_prev = e;
		end
	end

endmodule

//--- dv/tb_lcd_subsystem.sv
`include "lcd_config.svh"

module tb_lcd_subsystem;
	timeunit 1ns;
	timeprecision 100ps;

	import lcd_bus_pkg::*;
	import lcd_text_pkg::*;

	localparam int CLK_NS    = 4;
	localparam int US_NS     = `LCD_CLK_MHZ * CLK_NS;	// one microsecond of DUT time
	localparam int RESET_CYC = 16;
	localparam int MARGIN_US = 200;

	logic       clk;
	logic       arst_n;
	lcd_mode_t  mode;
	logic       char_valid;
	logic [7:0] char_data;
	logic       char_full;
	logic       lcd_e;
	logic       lcd_rs;
	logic       lcd_rw;
	logic [7:0] lcd_data;
	logic [9:0] cap_word;
	int         cap_count;
	logic       timing_err;

	lcd_word_t exp_q[$];	// reference words still to be seen
	lcd_word_t exp_word;
	cursor_t   cur;	// reference cursor
	int        seen = 0;
	int        n_words = 0;
	int        n_clears = 0;
	int        n_dropped = 0;
	int        clear_at;
	int        seed = 15758;
	string     greeting = "Hello, LCD panel!";

	lcd_subsystem u_lcd_subsystem (
		.clk        (clk),
		.arst_n     (arst_n),
		.mode       (mode),
		.char_valid (char_valid),
		.char_data  (char_data),
		.char_full  (char_full),
		.lcd_e      (lcd_e),
		.lcd_rs     (lcd_rs),
		.lcd_rw     (lcd_rw),
		.lcd_data   (lcd_data)
	);

	lcd_panel_model u_panel (
		.clk        (clk),
		.arst_n     (arst_n),
		.e          (lcd_e),
		.rs         (lcd_rs),
		.rw         (lcd_rw),
		.data       (lcd_data),
		.cap_word   (cap_word),
		.cap_count  (cap_count),
		.timing_err (timing_err)
	);

	task automatic stop_run(input string line);
		$display("%s", line);
		$display("=== FAIL ===");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic push_word(input logic rs, input logic [7:0] data);
		exp_q.push_back(lcd_word_t'{rs: rs, rw: 1'b0, data: data});
		n_words = n_words + 1;
	endtask

	// next row at column 0 and its set-address command
	task automatic move_row();
		cur.row = (cur.row == `LCD_ROWS - 1) ? 1'b0 : cur.row + 1'b1;
		cur.col = 4'd0;
		push_word(1'b0, 8'h80 | (cur.row ? `LCD_ROW1_BASE : 8'h00));
	endtask

	task automatic expect_char(input logic [7:0] c);
		case (c)
			CODE_FF: begin
				push_word(1'b0, 8'h01);
				cur      = '0;
				n_clears = n_clears + 1;
			end
			CODE_LF: move_row();
			default: begin
				push_word(1'b1, c);
				if (cur.col == `LCD_COLS - 1)
					move_row();	// row full
				else
					cur.col = cur.col + 1'b1;
			end
		endcase
	endtask

	function automatic logic [7:0] random_printable();
		int r;
		r = $random(seed);
		return 8'(32 + $unsigned(r) % 95);
	endfunction

	// one strobe from falling edge to falling edge
	task automatic send_char(input logic [7:0] c, input logic wait_room);
		while (wait_room && char_full)
			@(negedge clk);
		char_valid = 1'b1;
		char_data  = c;
		if (!char_full)
			expect_char(c);
		else
			n_dropped = n_dropped + 1;	// strobe lost to a full FIFO
		@(negedge clk);
		char_valid = 1'b0;
	endtask

	initial begin
		clk = 1'b0;
		forever #(CLK_NS / 2) clk = ~clk;
	end

	// each newly captured word against the head of the queue
	always @(negedge clk) begin
		if (cap_count != seen) begin
			if (exp_q.size() == 0) begin
				stop_run($sformatf("Fail %0t: unexpected panel word %h", $time, cap_word));
			end else begin
				exp_word = exp_q.pop_front();
				assert (cap_word == exp_word)
					else stop_run($sformatf("Fail %0t: word %0d expected %h seen %h",
						$time, seen, exp_word, cap_word));
				seen = seen + 1;
			end
		end
	end

	assert property (@(posedge clk) disable iff (!arst_n) !lcd_rw)
		else stop_run($sformatf("Fail %0t: rw driven high", $time));

	always @(posedge timing_err)
		stop_run("panel timing check failed");

	initial begin : watchdog
		int limit_ns;
		forever begin
			@(negedge clk);
			limit_ns = (`LCD_POWERUP_US + `LCD_INIT_END_US + MARGIN_US
				+ `LCD_CLEAR_US * n_clears + 60 * n_words) * US_NS;
			if ($time > limit_ns)
				stop_run("timeout: panel words missing");
		end
	end

	initial begin
		arst_n     = 1'b0;
		char_valid = 1'b0;
		char_data  = 8'h00;
		cur        = '0;
		mode       = '{n: 1'b1, f: 1'b0, d: 1'b1, c: 1'b1, b: 1'b0, id: 1'b1, s: 1'b0};
		push_word(1'b0, 8'h30 | {4'b0000, mode.n, mode.f, 2'b00});
		push_word(1'b0, 8'h08 | {5'b00000, mode.d, mode.c, mode.b});
		push_word(1'b0, 8'h01);
		push_word(1'b0, 8'h04 | {6'b000000, mode.id, mode.s});
		repeat (RESET_CYC) @(negedge clk);
		arst_n = 1'b1;

		for (int i = 0; i < greeting.len(); i++)
			send_char(greeting[i], 1'b1);	// 17th char wraps to row 1
		send_char(CODE_LF, 1'b1);
		repeat (2 * `LCD_COLS) send_char(random_printable(), 1'b1);	// both rows wrap
		send_char(CODE_LF, 1'b1);
		send_char(CODE_FF, 1'b1);
		clear_at = n_words;

		// burst while the writer sits out the clear time
		wait (seen >= clear_at);
		@(negedge clk);
		repeat (2 * `LCD_FIFO_DEPTH) send_char(random_printable(), 1'b0);
		assert (n_dropped == `LCD_FIFO_DEPTH)
			else stop_run($sformatf("Fail %0t: burst dropped %0d strobes, expected %0d",
				$time, n_dropped, `LCD_FIFO_DEPTH));
		send_char("E", 1'b1);
		send_char("N", 1'b1);
		send_char("D", 1'b1);

		wait (seen == n_words);
		#(2 * `LCD_WORD_US * US_NS);	// quiet period catches stray words
		$display("=== PASS ===");
		$finish;
	end

endmodule

//--- lcd_subsystem.f
+incdir+src
src/lcd_bus_pkg.sv
src/lcd_text_pkg.sv
src/lcd_word_if.sv
src/char_fifo.sv
src/lcd_driver.sv
src/lcd_text_writer.sv
src/lcd_subsystem.sv
dv/lcd_panel_model.sv
dv/tb_lcd_subsystem.sv

//--- src/char_fifo.sv
`include "lcd_config.svh"

module char_fifo (
	input  logic       clk,
	input  logic       arst_n,
	input  logic       wr_en,
	input  logic [7:0] wr_data,
	input  logic       rd_en,
	output logic [7:0] rd_data,
	output logic       empty,
	output logic       full
);
	localparam int DEPTH = `LCD_FIFO_DEPTH;
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	logic [7:0]       mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic [CNT_W-1:0] count_next;
	logic             do_wr;
	logic             do_rd;

	assign do_wr = wr_en && !full;	// overflow is dropped
	assign do_rd = rd_en && !empty;
	assign rd_data = mem[rd_ptr];	// head is visible without a read

	always_comb begin
		count_next = count;
		if (do_wr && !do_rd)
			count_next = count + 1'b1;
		else if (do_rd && !do_wr)
			count_next = count - 1'b1;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
			empty  <= 1'b1;
			full   <= 1'b0;
		end else begin
			if (do_wr)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			count <= count_next;
			empty <= (count_next == '0);
			full  <= (count_next == CNT_W'(DEPTH));
		end
	end

	always_ff @(posedge clk) begin
		if (do_wr)
			mem[wr_ptr] <= wr_data;
	end

endmodule

//--- src/lcd_bus_pkg.sv
package lcd_bus_pkg;

	// driver phase
	typedef enum logic [1:0] {
		PHASE_POWERUP,	// waiting for panel supply to settle
		PHASE_INIT,	// four-word init sequence
		PHASE_IDLE,	// ready for a request
		PHASE_PULSE	// timing one enable pulse
	} lcd_phase_e;

	// instruction opcodes, low bits are or'd in by the user
	typedef enum logic [7:0] {
		CMD_CLEAR      = 8'h01,
		CMD_ENTRY_MODE = 8'h04,	// | {id, s}
		CMD_DISP_CTRL  = 8'h08,	// | {d, c, b}
		CMD_FUNC_SET   = 8'h30,	// 8-bit bus, | {n, f, 2'b00}
		CMD_SET_ADDR   = 8'h80	// | ddram address
	} lcd_cmd_e;

	typedef struct packed {
		logic       rs;	// 1 for data, 0 for instruction
		logic       rw;
		logic [7:0] data;
	} lcd_word_t;

	// init mode bits, same order as the panel's instruction fields
	typedef struct packed {
		logic n;	// two-line display
		logic f;	// 5x10 font
		logic d;	// display on
		logic c;	// cursor on
		logic b;	// cursor blink
		logic id;	// increment address
		logic s;	// shift display
	} lcd_mode_t;

endpackage

//--- src/lcd_config.svh
`ifndef LCD_CONFIG_SVH
`define LCD_CONFIG_SVH

// clock rate, also the cycles-per-microsecond factor
`define LCD_CLK_MHZ 25

// driver timing points in microseconds
`define LCD_POWERUP_US 500
`define LCD_INIT_END_US 440
`define LCD_WORD_US 50
`define LCD_E_START_US 1
`define LCD_E_END_US 14

// clear-display execution time, waited out by the writer
`define LCD_CLEAR_US 1600

// panel geometry
`define LCD_COLS 16
`define LCD_ROWS 2
`define LCD_ROW1_BASE 8'h40

// character buffer
`define LCD_FIFO_DEPTH 4

`endif

//--- src/lcd_driver.sv
`include "lcd_config.svh"

module lcd_driver (
	input  logic                   clk,
	input  logic                   arst_n,
	input  lcd_bus_pkg::lcd_mode_t mode,
	lcd_word_if.driver             word_port,
	output logic                   e,
	output logic                   rs,
	output logic                   rw,
	output logic [7:0]             lcd_data
);
	import lcd_bus_pkg::*;

	localparam int CYC_US       = `LCD_CLK_MHZ;
	localparam int POWERUP_CYC  = `LCD_POWERUP_US * CYC_US;
	localparam int INIT_END_CYC = `LCD_INIT_END_US * CYC_US;
	localparam int WORD_CYC     = `LCD_WORD_US * CYC_US;
	localparam int E_START_CYC  = `LCD_E_START_US * CYC_US;
	localparam int E_END_CYC    = `LCD_E_END_US * CYC_US;
	localparam int MAX_CYC      = (POWERUP_CYC > INIT_END_CYC) ? POWERUP_CYC : INIT_END_CYC;
	localparam int CNT_W        = $clog2(MAX_CYC + 1);

	// init sequence edges, 10 us pulses with 50/50/200/100 us gaps
	localparam int FS_END  = 10 * CYC_US;
	localparam int DC_BEG  = 60 * CYC_US;
	localparam int DC_END  = 70 * CYC_US;
	localparam int CLR_BEG = 120 * CYC_US;
	localparam int CLR_END = 130 * CYC_US;
	localparam int EM_BEG  = 330 * CYC_US;
	localparam int EM_END  = 340 * CYC_US;

	lcd_phase_e       phase;
	logic [CNT_W-1:0] cnt;
	logic [CNT_W-1:0] cnt_nxt;
	logic             busy_q;
	logic             init_e;
	logic [7:0]       init_data;

	assign cnt_nxt = cnt + 1'b1;
	assign word_port.busy = busy_q;

	// init word for the current count, data held through the following gap
	always_comb begin
		init_e = 1'b0;
		if (cnt < CNT_W'(FS_END)) begin
			init_e    = 1'b1;
			init_data = CMD_FUNC_SET | {4'b0000, mode.n, mode.f, 2'b00};
		end else if (cnt < CNT_W'(DC_BEG)) begin
			init_data = CMD_FUNC_SET | {4'b0000, mode.n, mode.f, 2'b00};
		end else if (cnt < CNT_W'(DC_END)) begin
			init_e    = 1'b1;
			init_data = CMD_DISP_CTRL | {5'b00000, mode.d, mode.c, mode.b};
		end else if (cnt < CNT_W'(CLR_BEG)) begin
			init_data = CMD_DISP_CTRL | {5'b00000, mode.d, mode.c, mode.b};
		end else if (cnt < CNT_W'(CLR_END)) begin
			init_e    = 1'b1;
			init_data = CMD_CLEAR;
		end else if (cnt < CNT_W'(EM_BEG)) begin
			init_data = CMD_CLEAR;
		end else if (cnt < CNT_W'(EM_END)) begin
			init_e    = 1'b1;
			init_data = CMD_ENTRY_MODE | {6'b000000, mode.id, mode.s};
		end else begin
			init_data = CMD_ENTRY_MODE | {6'b000000, mode.id, mode.s};
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			phase    <= PHASE_POWERUP;
			cnt      <= '0;
			busy_q   <= 1'b1;
			e        <= 1'b0;
			rs       <= 1'b0;
			rw       <= 1'b0;
			lcd_data <= 8'h00;
		end else begin
			case (phase)
				PHASE_POWERUP: begin
					if (cnt == CNT_W'(POWERUP_CYC - 1)) begin
						cnt   <= '0;
						phase <= PHASE_INIT;
					end else begin
						cnt <= cnt_nxt;
					end
				end
				PHASE_INIT: begin
					rs       <= 1'b0;	// instructions only
					rw       <= 1'b0;
					e        <= init_e;
					lcd_data <= init_data;
					if (cnt == CNT_W'(INIT_END_CYC - 1)) begin
						cnt      <= '0;
						e        <= 1'b0;
						lcd_data <= 8'h00;
						phase    <= PHASE_IDLE;	// busy drops one cycle later
					end else begin
						cnt <= cnt_nxt;
					end
				end
				PHASE_IDLE: begin
					cnt <= '0;
					if (word_port.enable && !busy_q) begin
						rs       <= word_port.word.rs;
						rw       <= word_port.word.rw;
						lcd_data <= word_port.word.data;
						busy_q   <= 1'b1;
						phase    <= PHASE_PULSE;
					end else begin
						busy_q   <= 1'b0;
						rs       <= 1'b0;
						rw       <= 1'b0;
						lcd_data <= 8'h00;
					end
				end
				PHASE_PULSE: begin
					cnt <= cnt_nxt;
					e   <= (cnt_nxt >= CNT_W'(E_START_CYC)) && (cnt_nxt < CNT_W'(E_END_CYC));
					if (cnt_nxt == CNT_W'(WORD_CYC)) begin
						e        <= 1'b0;
						rs       <= 1'b0;
						rw       <= 1'b0;
						lcd_data <= 8'h00;
						phase    <= PHASE_IDLE;
					end
				end
				default: phase <= PHASE_POWERUP;
			endcase
		end
	end

endmodule

//--- src/lcd_subsystem.sv
module lcd_subsystem (
	input  logic                   clk,
	input  logic                   arst_n,
	input  lcd_bus_pkg::lcd_mode_t mode,
	input  logic                   char_valid,
	input  logic [7:0]             char_data,
	output logic                   char_full,
	output logic                   lcd_e,
	output logic                   lcd_rs,
	output logic                   lcd_rw,
	output logic [7:0]             lcd_data
);
	logic [7:0] fifo_data;
	logic       fifo_empty;
	logic       fifo_pop;

	lcd_word_if word_bus ();	// writer to driver requests

	char_fifo u_char_fifo (
		.clk     (clk),
		.arst_n  (arst_n),
		.wr_en   (char_valid),
		.wr_data (char_data),
		.rd_en   (fifo_pop),
		.rd_data (fifo_data),
		.empty   (fifo_empty),
		.full    (char_full)
	);

	lcd_text_writer u_text_writer (
		.clk       (clk),
		.arst_n    (arst_n),
		.empty     (fifo_empty),
		.char_data (fifo_data),
		.pop       (fifo_pop),
		.word_port (word_bus.writer)
	);

	lcd_driver u_driver (
		.clk       (clk),
		.arst_n    (arst_n),
		.mode      (mode),
		.word_port (word_bus.driver),
		.e         (lcd_e),
		.rs        (lcd_rs),
		.rw        (lcd_rw),
		.lcd_data  (lcd_data)
	);

endmodule

//--- src/lcd_text_pkg.sv
package lcd_text_pkg;

	typedef enum logic [2:0] {
		W_IDLE,
		W_SEND_CHAR,
		W_SEND_ADDR,
		W_SEND_CLEAR,
		W_WAIT_BUSY,	// word accepted, driver still pulsing
		W_WAIT_CLEAR	// panel executing clear
	} writer_state_e;

	// characters handled as commands rather than printed
	typedef enum logic [7:0] {
		CODE_LF = 8'h0A,	// next row, column 0
		CODE_FF = 8'h0C	// clear screen, home cursor
	} ctrl_code_e;

	// 16x2 panel, so one row bit and four column bits
	typedef struct packed {
		logic       row;
		logic [3:0] col;
	} cursor_t;

endpackage

//--- src/lcd_text_writer.sv
`include "lcd_config.svh"

module lcd_text_writer (
	input  logic       clk,
	input  logic       arst_n,
	input  logic       empty,
	input  logic [7:0] char_data,
	output logic       pop,
	lcd_word_if.writer word_port
);
	import lcd_bus_pkg::*;
	import lcd_text_pkg::*;

	localparam int CLEAR_CYC = `LCD_CLEAR_US * `LCD_CLK_MHZ;
	localparam int CLR_W     = $clog2(CLEAR_CYC);

	writer_state_e    state;
	writer_state_e    ret_state;	// where to go once busy falls
	cursor_t          cursor;
	logic             row_next;
	logic [7:0]       row_base;
	logic [7:0]       char_q;
	logic             enable_q;
	lcd_word_t        word_q;
	lcd_word_t        next_word;
	logic             send_go;
	logic [CLR_W-1:0] clr_cnt;

	assign pop = (state == W_IDLE) && !empty;
	assign row_next = (cursor.row == 1'(`LCD_ROWS - 1)) ? 1'b0 : cursor.row + 1'b1;
	assign row_base = cursor.row ? `LCD_ROW1_BASE : 8'h00;
	assign send_go = (state inside {W_SEND_CHAR, W_SEND_ADDR, W_SEND_CLEAR}) && !word_port.busy;

	assign word_port.enable = enable_q;
	assign word_port.word   = word_q;

	always_comb begin
		next_word.rw = 1'b0;	// never reads the panel
		case (state)
			W_SEND_CHAR: begin
				next_word.rs   = 1'b1;
				next_word.data = char_q;
			end
			W_SEND_ADDR: begin
				next_word.rs   = 1'b0;
				next_word.data = CMD_SET_ADDR | row_base;	// cursor already on new row
			end
			default: begin
				next_word.rs   = 1'b0;
				next_word.data = CMD_CLEAR;
			end
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state     <= W_IDLE;
			ret_state <= W_IDLE;
			cursor    <= '0;
			enable_q  <= 1'b0;
			clr_cnt   <= '0;
		end else begin
			enable_q <= 1'b0;
			case (state)
				W_IDLE: begin
					if (!empty) begin
						case (char_data)
							CODE_FF: state <= W_SEND_CLEAR;
							CODE_LF: begin
								cursor <= '{row: row_next, col: 4'd0};
								state  <= W_SEND_ADDR;
							end
							default: state <= W_SEND_CHAR;
						endcase
					end
				end
				W_SEND_CHAR: begin
					if (send_go) begin
						enable_q <= 1'b1;
						state    <= W_WAIT_BUSY;
						if (cursor.col == 4'(`LCD_COLS - 1)) begin	// row full
							cursor    <= '{row: row_next, col: 4'd0};
							ret_state <= W_SEND_ADDR;
						end else begin
							cursor.col <= cursor.col + 1'b1;
							ret_state  <= W_IDLE;
						end
					end
				end
				W_SEND_ADDR: begin
					if (send_go) begin
						enable_q  <= 1'b1;
						ret_state <= W_IDLE;
						state     <= W_WAIT_BUSY;
					end
				end
				W_SEND_CLEAR: begin
					if (send_go) begin
						enable_q  <= 1'b1;
						cursor    <= '0;	// panel homes on clear
						ret_state <= W_WAIT_CLEAR;
						state     <= W_WAIT_BUSY;
					end
				end
				W_WAIT_BUSY: begin
					// busy rises one cycle after the strobe, so skip that cycle
					if (!enable_q && !word_port.busy) begin
						clr_cnt <= '0;
						state   <= ret_state;
					end
				end
				W_WAIT_CLEAR: begin
					if (clr_cnt == CLR_W'(CLEAR_CYC - 1))
						state <= W_IDLE;
					else
						clr_cnt <= clr_cnt + 1'b1;
				end
				default: state <= W_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (pop)
			char_q <= char_data;
		if (send_go)
			word_q <= next_word;
	end

endmodule

//--- src/lcd_word_if.sv
interface lcd_word_if;
	import lcd_bus_pkg::*;

	logic      enable;	// one-cycle request strobe
	lcd_word_t word;	// valid with enable
	logic      busy;	// driver level, high while a word is in flight

	modport writer (
		output enable,
		output word,
		input  busy
	);

	modport driver (
		input  enable,
		input  word,
		output busy
	);

endinterface
